// File: src/fc_pkg.sv
// Shared sizes, frame address map, vector types and FSM states of the FC layer
package fc_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic signed [7:0]  byte_t;    // Input, weight, bias or output value
    typedef logic        [31:0] word_t;    // One stream / RAM word
    typedef logic        [3:0]  addr_t;    // Frame RAM address
    typedef logic signed [18:0] acc_t;     // Eight products plus scaled bias

    ////////////////////////////////////////////////////////////
    // Layer sizes
    ////////////////////////////////////////////////////////////

    localparam int IN_COUNT  = 8;
    localparam int OUT_COUNT = 4;

    // Frame layout in 32-bit words
    localparam int WORDS_IN    = 2;
    localparam int WORDS_W     = 8;    // Two words per weight row
    localparam int WORDS_B     = 1;
    localparam int FRAME_WORDS = WORDS_IN + WORDS_W + WORDS_B;

    ////////////////////////////////////////////////////////////
    // RAM address map
    ////////////////////////////////////////////////////////////

    localparam addr_t IN_BASE = 4'd0;
    localparam addr_t W_BASE  = 4'd4;
    localparam addr_t B_BASE  = 4'd14;

    // Stream loader
    typedef enum logic {
        L_IDLE,
        L_RECEIVE
    } load_state_t;

    // Layer engine
    typedef enum logic [2:0] {
        C_IDLE,
        C_READ_IN,     // Two input words
        C_READ_BIAS,   // One bias word
        C_READ_W,      // Two words of the current weight row
        C_ACCUM,       // One product per cycle
        C_BIAS_ADD,
        C_STORE,       // Quantize into the output byte
        C_SEND
    } calc_state_t;

endpackage

// File: src/fc_frame_loader.sv
// Frame loader, writes the incoming word stream into the frame RAM and flags a full frame
module fc_frame_loader (
    input  logic          clk,
    input  logic          rstn,
    input  logic          r_valid,
    input  fc_pkg::word_t in_data,
    output logic          wr_en,
    output fc_pkg::addr_t wr_addr,
    output fc_pkg::word_t wr_data,
    output logic          load_done
);

    fc_pkg::load_state_t state;
    logic [3:0]          cnt;        // Position of the next word in the frame
    fc_pkg::addr_t       map_addr;

    ////////////////////////////////////////////////////////////
    // Stream position to RAM region
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (cnt < fc_pkg::WORDS_IN) begin
            map_addr = fc_pkg::IN_BASE + cnt;
        end else if (cnt < fc_pkg::WORDS_IN + fc_pkg::WORDS_W) begin
            map_addr = fc_pkg::W_BASE + (cnt - 4'(fc_pkg::WORDS_IN));
        end else begin
            // Bias region follows the last weight row
            map_addr = fc_pkg::B_BASE + (cnt - 4'(fc_pkg::WORDS_IN + fc_pkg::WORDS_W));
        end
    end

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= fc_pkg::L_IDLE;
            cnt       <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            load_done <= 1'b0;
        end else begin
            wr_en     <= 1'b0;     // Single-cycle write strobes
            load_done <= 1'b0;
            case (state)
                fc_pkg::L_IDLE: begin
                    if (r_valid) begin
                        wr_en   <= 1'b1;
                        wr_addr <= map_addr;
                        cnt     <= cnt + 4'd1;
                        state   <= fc_pkg::L_RECEIVE;
                    end
                end
                fc_pkg::L_RECEIVE: begin
                    if (r_valid) begin
                        wr_en   <= (cnt < fc_pkg::FRAME_WORDS);  // Ignore overlong frames
                        wr_addr <= map_addr;
                        cnt     <= cnt + 4'd1;
                    end else begin
                        // Stream ended, frame is in RAM
                        load_done <= 1'b1;
                        cnt       <= '0;
                        state     <= fc_pkg::L_IDLE;
                    end
                end
                default: state <= fc_pkg::L_IDLE;
            endcase
        end
    end

    // Write data follows the valid word by one cycle
    always_ff @(posedge clk) begin
        if (r_valid) begin
            wr_data <= in_data;
        end
    end

endmodule

// File: src/fc_frame_ram.sv
// Frame RAM, 32-bit words with one write port and a registered read port
module fc_frame_ram #(
    parameter int ADDR_W = 4
) (
    input  logic          clk,
    input  logic          wr_en,
    input  fc_pkg::addr_t wr_addr,
    input  fc_pkg::word_t wr_data,
    input  logic          rd_en,
    input  fc_pkg::addr_t rd_addr,
    output fc_pkg::word_t rd_data
);

    fc_pkg::word_t mem [2**ADDR_W];

    // Block RAM style, same-address read gets the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // One cycle read latency
        end
    end

endmodule

// File: src/fc_layer_engine.sv
// Layer engine, reads the frame, accumulates each output row and packs the saturated bytes
module fc_layer_engine #(
    parameter int FRAC_BITS = 6
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          load_done,
    input  fc_pkg::word_t rd_data,
    output logic          rd_en,
    output fc_pkg::addr_t rd_addr,
    output fc_pkg::word_t out_data,
    output logic          t_valid
);

    fc_pkg::calc_state_t state;
    logic [2:0]          step;       // Word index while reading, input index while accumulating
    logic [1:0]          out_idx;    // Output being computed
    logic                rd_pend;    // rd_data holds the last requested word

    logic [fc_pkg::IN_COUNT*8-1:0] in_vec;
    logic [fc_pkg::IN_COUNT*8-1:0] w_row;   // Current weight row only
    fc_pkg::word_t                 bias_word;
    fc_pkg::acc_t                  acc;

    fc_pkg::byte_t     in_b;
    fc_pkg::byte_t     w_b;
    fc_pkg::byte_t     bias_b;
    logic signed [15:0] prod;
    fc_pkg::acc_t      bias_scaled;
    fc_pkg::acc_t      shifted;
    fc_pkg::byte_t     q_byte;

    ////////////////////////////////////////////////////////////
    // Operand select and quantizer
    ////////////////////////////////////////////////////////////

    assign in_b        = in_vec[8*step +: 8];
    assign w_b         = w_row[8*step +: 8];
    assign bias_b      = bias_word[8*out_idx +: 8];
    assign prod        = in_b * w_b;                                  // Full precision product
    assign bias_scaled = fc_pkg::acc_t'(bias_b) <<< FRAC_BITS;        // Bias into the sum's scale
    assign shifted     = acc >>> FRAC_BITS;                           // Rounds toward minus infinity

    always_comb begin
        if (shifted > fc_pkg::acc_t'(127)) begin
            q_byte = fc_pkg::byte_t'(8'h7f);
        end else if (shifted < fc_pkg::acc_t'(-128)) begin
            q_byte = fc_pkg::byte_t'(8'h80);
        end else begin
            q_byte = fc_pkg::byte_t'(shifted[7:0]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= fc_pkg::C_IDLE;
            step     <= '0;
            out_idx  <= '0;
            rd_en    <= 1'b0;
            rd_addr  <= '0;
            rd_pend  <= 1'b0;
            t_valid  <= 1'b0;
            out_data <= '0;
        end else begin
            rd_en   <= 1'b0;
            rd_pend <= rd_en;    // Data lands one cycle after the RAM sees rd_en
            t_valid <= 1'b0;
            case (state)
                fc_pkg::C_IDLE: begin
                    if (load_done) begin
                        rd_en   <= 1'b1;
                        rd_addr <= fc_pkg::IN_BASE;
                        step    <= '0;
                        out_idx <= '0;
                        state   <= fc_pkg::C_READ_IN;
                    end
                end
                fc_pkg::C_READ_IN: begin
                    if (rd_pend) begin
                        rd_en <= 1'b1;
                        if (step == 3'(fc_pkg::WORDS_IN - 1)) begin
                            rd_addr <= fc_pkg::B_BASE;
                            state   <= fc_pkg::C_READ_BIAS;
                        end else begin
                            rd_addr <= rd_addr + 4'd1;
                            step    <= step + 3'd1;
                        end
                    end
                end
                fc_pkg::C_READ_BIAS: begin
                    if (rd_pend) begin
                        rd_en   <= 1'b1;
                        rd_addr <= fc_pkg::W_BASE;    // Row 0
                        step    <= '0;
                        state   <= fc_pkg::C_READ_W;
                    end
                end
                fc_pkg::C_READ_W: begin
                    // A weight row is as wide as the input vector
                    if (rd_pend) begin
                        if (step == 3'(fc_pkg::WORDS_IN - 1)) begin
                            step  <= '0;
                            state <= fc_pkg::C_ACCUM;
                        end else begin
                            rd_en   <= 1'b1;
                            rd_addr <= rd_addr + 4'd1;
                            step    <= step + 3'd1;
                        end
                    end
                end
                fc_pkg::C_ACCUM: begin
                    if (step == 3'(fc_pkg::IN_COUNT - 1)) begin
                        state <= fc_pkg::C_BIAS_ADD;
                    end
                    step <= step + 3'd1;
                end
                fc_pkg::C_BIAS_ADD: state <= fc_pkg::C_STORE;
                fc_pkg::C_STORE: begin
                    out_data[8*out_idx +: 8] <= q_byte;
                    if (out_idx == 2'(fc_pkg::OUT_COUNT - 1)) begin
                        state <= fc_pkg::C_SEND;
                    end else begin
                        // Fetch the next row
                        out_idx <= out_idx + 2'd1;
                        rd_en   <= 1'b1;
                        rd_addr <= fc_pkg::W_BASE + {1'b0, out_idx + 2'd1, 1'b0};
                        step    <= '0;
                        state   <= fc_pkg::C_READ_W;
                    end
                end
                fc_pkg::C_SEND: begin
                    t_valid <= 1'b1;      // out_data already holds all four bytes
                    state   <= fc_pkg::C_IDLE;
                end
                default: state <= fc_pkg::C_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand registers and accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            fc_pkg::C_READ_IN: begin
                if (rd_pend) begin
                    in_vec <= {rd_data, in_vec[63:32]};   // First word ends up low
                end
            end
            fc_pkg::C_READ_BIAS: begin
                if (rd_pend) begin
                    bias_word <= rd_data;
                end
            end
            fc_pkg::C_READ_W: begin
                if (rd_pend) begin
                    w_row <= {rd_data, w_row[63:32]};
                end
                acc <= '0;                                // Fresh sum per output
            end
            fc_pkg::C_ACCUM:    acc <= acc + fc_pkg::acc_t'(prod);
            fc_pkg::C_BIAS_ADD: acc <= acc + bias_scaled;
            default: begin
            end
        endcase
    end

endmodule

// File: src/fc_layer_top.sv
// FC layer top, connects stream loader, frame RAM and layer engine
module fc_layer_top #(
    parameter int ADDR_W    = 4,
    parameter int FRAC_BITS = 6
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          r_valid,
    input  fc_pkg::word_t in_data,
    output fc_pkg::word_t out_data,
    output logic          t_valid
);

    // Loader to RAM
    logic          wr_en;
    fc_pkg::addr_t wr_addr;
    fc_pkg::word_t wr_data;

    // Engine side
    logic          load_done;
    logic          rd_en;
    fc_pkg::addr_t rd_addr;
    fc_pkg::word_t rd_data;

    fc_frame_loader loader_i (
        .clk       (clk),
        .rstn      (rstn),
        .r_valid   (r_valid),
        .in_data   (in_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .load_done (load_done)
    );

    fc_frame_ram #(
        .ADDR_W (ADDR_W)
    ) ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fc_layer_engine #(
        .FRAC_BITS (FRAC_BITS)
    ) engine_i (
        .clk       (clk),
        .rstn      (rstn),
        .load_done (load_done),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .out_data  (out_data),
        .t_valid   (t_valid)
    );

endmodule

// File: tests/tb_fc_layer.sv
// FC layer testbench, applies a table of frames and compares out_data with a reference model
module tb_fc_layer;

    localparam int FRAC_BITS = 6;
    localparam int NUM_ROWS  = 12;     // Four directed frames, then random ones
    localparam int N_WORDS   = 11;
    localparam int TIMEOUT   = 200;

    logic        clk;
    logic        rstn;
    logic        r_valid;
    logic [31:0] in_data;
    logic [31:0] out_data;
    logic        t_valid;

    logic [31:0] frame_tab  [NUM_ROWS][N_WORDS];
    logic [31:0] expect_tab [NUM_ROWS];

    fc_layer_top #(
        .ADDR_W    (4),
        .FRAC_BITS (FRAC_BITS)
    ) dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .r_valid  (r_valid),
        .in_data  (in_data),
        .out_data (out_data),
        .t_valid  (t_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] layer_ref(input int row);
        int               acc;
        int               i;
        int               j;
        logic signed [7:0] x;
        logic signed [7:0] w;
        logic signed [7:0] b;
        logic [31:0]      res;
        res = '0;
        for (j = 0; j < 4; j++) begin
            acc = 0;
            for (i = 0; i < 8; i++) begin
                x   = frame_tab[row][i / 4][8 * (i % 4) +: 8];
                w   = frame_tab[row][2 + 2 * j + i / 4][8 * (i % 4) +: 8];
                acc = acc + int'(x) * int'(w);
            end
            b   = frame_tab[row][10][8 * j +: 8];
            acc = acc + int'(b) * (1 << FRAC_BITS);
            acc = acc >>> FRAC_BITS;                 // Floor division
            if (acc > 127) acc = 127;
            if (acc < -128) acc = -128;
            res[8 * j +: 8] = acc[7:0];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // Inputs and bias given, all weights zero
    task automatic set_row(input int row, input logic [31:0] in0, input logic [31:0] in1,
                           input logic [31:0] bias);
        int w;
        frame_tab[row][0] = in0;
        frame_tab[row][1] = in1;
        for (w = 2; w < 10; w++) begin
            frame_tab[row][w] = '0;
        end
        frame_tab[row][10] = bias;
    endtask

    task automatic fill_directed();
        int w;
        // Zero inputs, each output equals its bias byte
        set_row(0, 32'h0, 32'h0, 32'h7F809C11);
        for (w = 2; w < 10; w++) begin
            frame_tab[0][w] = 32'h5A3C1E00 + w;
        end
        // Inputs at 1.0, one weight per row at input 1, 3, 4 and 6
        set_row(1, 32'h40404040, 32'h40404040, 32'hFC030201);
        frame_tab[1][2] = 32'h00000A00;
        frame_tab[1][4] = 32'hEC000000;
        frame_tab[1][7] = 32'h00000021;
        frame_tab[1][9] = 32'h00F90000;
        // Saturation high and low, then large partial sums with an exact result
        set_row(2, 32'h7F7F7F7F, 32'h7F7F7F7F, 32'h80000010);
        frame_tab[2][2] = 32'h7F7F7F7F;
        frame_tab[2][3] = 32'h7F7F7F7F;
        frame_tab[2][4] = 32'h80808080;
        frame_tab[2][5] = 32'h80808080;
        frame_tab[2][6] = 32'h7F7F7F7F;
        frame_tab[2][7] = 32'h82828282;
        frame_tab[2][8] = 32'h10101010;
        frame_tab[2][9] = 32'h10101010;
        // Raw sums -1, -64, -65 and 63
        set_row(3, 32'h00000001, 32'h0, 32'h0);
        frame_tab[3][2] = 32'h000000FF;
        frame_tab[3][4] = 32'h000000C0;
        frame_tab[3][6] = 32'h000000BF;
        frame_tab[3][8] = 32'h0000003F;
    endtask

    task automatic send_frame(input int row);
        int w;
        for (w = 0; w < N_WORDS; w++) begin
            @(negedge clk);
            r_valid = 1'b1;
            in_data = frame_tab[row][w];
        end
        @(negedge clk);
        r_valid = 1'b0;
        in_data = '0;
    endtask

    task automatic wait_result(input int row);
        int cycles;
        cycles = 0;
        while (!t_valid) begin
            if (cycles == TIMEOUT) begin
                $display("Frame %0d: t_valid never came within %0d cycles", row, TIMEOUT);
                $display("Errors found");
                $fatal(1, "timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int row;
        int w;
        rstn     = 1'b0;
        r_valid  = 1'b0;
        in_data  = '0;
        void'($urandom(77));
        fill_directed();
        for (row = 4; row < NUM_ROWS; row++) begin
            for (w = 0; w < N_WORDS; w++) begin
                frame_tab[row][w] = $urandom();
            end
        end
        for (row = 0; row < NUM_ROWS; row++) begin
            expect_tab[row] = layer_ref(row);
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value("out_data after reset", out_data, 32'h0);
        for (row = 0; row < NUM_ROWS; row++) begin
            send_frame(row);
            wait_result(row);
            check_value($sformatf("frame %0d out_data", row), out_data, expect_tab[row]);
            @(negedge clk);
            check_value($sformatf("frame %0d t_valid one cycle later", row),
                        {31'b0, t_valid}, 32'h0);    // Pulse is one cycle wide
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: list.f
src/fc_pkg.sv
src/fc_frame_loader.sv
src/fc_frame_ram.sv
src/fc_layer_engine.sv
src/fc_layer_top.sv
tests/tb_fc_layer.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_fc_layer
RTL_TOP    = fc_layer_top
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
